/* files.f */
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/ifu.sv
rtl/idu.sv
rtl/regfile.sv
rtl/exu.sv
rtl/lsu.sv
rtl/mem_arbiter.sv
rtl/cpu_top.sv
sim/tb_clock.sv
sim/cpu_checker.sv
sim/tb_top.sv

/* sim/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int          nregs       = 16;
    localparam int          cycle_ns    = 40;
    localparam int          mem_words   = 256;
    localparam int          total_insts = 41; // 10 + 4 + 7 + 10 + 7 + 3.
    localparam logic [31:0] reset_pc    = 32'h0000_0000;
    localparam logic [31:0] data_base   = 32'h0000_0200;
    localparam logic [31:0] load_word   = 32'h1357_9bdf;
    localparam logic [31:0] ebreak_inst = 32'h0010_0073;

    logic        clk;
    logic        reset;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_done;
    logic        retire;
    logic        halted;

    logic [31:0] mem [mem_words];
    logic [31:0] prog [$];
    logic [31:0] store_addr [$];
    logic [31:0] store_data [$];
    logic [31:0] fetch_addr [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          req_count;
    int          retire_count;
    int          test_errors;
    int          errors;
    int          failed;
    int          tests_run;
    bit          random_latency;

    tb_clock #(.period_ns(cycle_ns)) u_clock (.clk(clk));

    cpu_top #(.nregs(nregs), .reset_pc(reset_pc)) u_dut (
        .clk(clk), .reset(reset), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .mem_done(mem_done), .retire(retire), .halted(halted)
    );

    // rv32 encodings.
    function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] add_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] upper);
        return {upper, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_inst(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // memory model that serves one request at a time.
    initial begin : memory_model
        int   lat;
        int   idx;
        logic is_store;
        mem_done  = 1'b0;
        mem_rdata = '0;
        void'($urandom(42));
        forever begin
            @(negedge clk);
            if (!reset && mem_req === 1'b1) begin
                req_count++;
                idx      = mem_addr[9:2];
                is_store = mem_we;
                if (is_store) begin
                    store_addr.push_back(mem_addr);
                    store_data.push_back(mem_wdata);
                    mem[idx] = mem_wdata;
                end else if (mem_addr < data_base) begin
                    fetch_addr.push_back(mem_addr);
                end
                lat = random_latency ? ($urandom % 4) + 1 : 1;
                repeat (lat) @(posedge clk);
                #1;
                mem_done  = 1'b1;
                mem_rdata = is_store ? '0 : mem[idx];
                @(posedge clk);
                #1;
                mem_done = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && retire === 1'b1) begin
            retire_count++;
        end
    end

    initial begin : watchdog
        #(total_insts * 12 * cycle_ns);
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic compare_word(input string name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: %s expected %h, actual %h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic prepare_test();
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'hc0de_0000 ^ (i << 2);
        end
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        test_errors = 0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        store_addr.delete();
        store_data.delete();
        fetch_addr.delete();
        req_count    = 0;
        retire_count = 0;
        #1;
        reset = 1'b0;
    endtask

    task automatic run_program(input string name, input int n_insts);
        int cycles;
        for (int i = 0; i < prog.size(); i++) begin
            mem[(reset_pc >> 2) + i] = prog[i];
        end
        apply_reset();
        cycles = 0;
        while (halted !== 1'b1 && cycles < n_insts * 12) begin
            @(negedge clk);
            cycles++;
        end
        assert (halted === 1'b1) else begin
            $display("[ERROR] %s: the core did not halt within %0d cycles", name, cycles);
            test_errors++;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic check_stores(input string name);
        assert (store_addr.size() == exp_addr.size()) else begin
            $display("[ERROR] %s: store count expected %0d, actual %0d", name,
                     exp_addr.size(), store_addr.size());
            test_errors++;
        end
        for (int i = 0; i < exp_addr.size() && i < store_addr.size(); i++) begin
            compare_word(name, "store address", exp_addr[i], store_addr[i]);
            compare_word(name, "store data", exp_data[i], store_data[i]);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
    endtask

    task automatic arith_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        a = 5;
        b = a + 7;
        c = a + b;
        d = c - 20;
        e = d + c;
        prepare_test();
        prog.push_back(addi_inst(1, 0, 12'd5));
        prog.push_back(addi_inst(2, 1, 12'd7));
        prog.push_back(add_inst(3, 1, 2));
        prog.push_back(addi_inst(4, 3, -12'sd20));
        prog.push_back(add_inst(5, 4, 3));
        prog.push_back(addi_inst(6, 0, data_base[11:0]));
        prog.push_back(sw_inst(3, 6, 12'd0));
        prog.push_back(sw_inst(4, 6, 12'd4));
        prog.push_back(sw_inst(5, 6, 12'd8));
        prog.push_back(ebreak_inst);
        run_program("arith", 10);
        exp_addr = '{data_base, data_base + 4, data_base + 8};
        exp_data = '{c, d, e};
        check_stores("arith");
        finish_test("arith");
    endtask

    task automatic constant_test();
        logic [31:0] k;
        logic [31:0] hi;
        k  = 32'h1234_5ffc; // low part is negative, so lui takes the carry.
        hi = (k + 32'h800) >> 12;
        prepare_test();
        prog.push_back(lui_inst(1, hi[19:0]));
        prog.push_back(addi_inst(1, 1, k[11:0]));
        prog.push_back(sw_inst(1, 1, 12'd0));
        prog.push_back(ebreak_inst);
        run_program("lui_const", 4);
        exp_addr.push_back(k);
        exp_data.push_back(k);
        check_stores("lui_const");
        finish_test("lui_const");
    endtask

    task automatic build_load_store();
        prog.push_back(addi_inst(1, 0, data_base[11:0]));
        prog.push_back(addi_inst(3, 0, 12'h123));
        prog.push_back(lw_inst(2, 1, 12'd4));
        prog.push_back(add_inst(4, 2, 3)); // uses the loaded word at once.
        prog.push_back(sw_inst(4, 1, 12'd12));
        prog.push_back(sw_inst(4, 1, -12'sd8));
        prog.push_back(ebreak_inst);
        mem[(data_base >> 2) + 1] = load_word;
        exp_addr = '{data_base + 12, data_base - 8};
        exp_data = '{load_word + 32'h123, load_word + 32'h123};
    endtask

    task automatic load_store_test();
        prepare_test();
        build_load_store();
        run_program("load_store", 7);
        check_stores("load_store");
        finish_test("load_store");
    endtask

    task automatic zero_reg_test();
        prepare_test();
        prog.push_back(addi_inst(0, 0, 12'd99));
        prog.push_back(addi_inst(1, 0, data_base[11:0]));
        prog.push_back(add_inst(0, 1, 1));
        prog.push_back(addi_inst(2, 0, 12'd33));
        prog.push_back({7'b0100000, 5'd1, 5'd1, 3'b000, 5'd2, 7'b0110011}); // sub x2.
        prog.push_back({12'h055, 5'd0, 3'b100, 5'd3, 7'b0010011}); // xori x3.
        prog.push_back(sw_inst(0, 1, 12'd0));
        prog.push_back(sw_inst(2, 1, 12'd4));
        prog.push_back(sw_inst(3, 1, 12'd8));
        prog.push_back(ebreak_inst);
        run_program("zero_reg", 10);
        exp_addr = '{data_base, data_base + 4, data_base + 8};
        exp_data = '{32'd0, 32'd33, 32'd0};
        check_stores("zero_reg");
        compare_word("zero_reg", "retire count", 10, retire_count);
        finish_test("zero_reg");
    endtask

    task automatic random_latency_test();
        prepare_test();
        build_load_store();
        random_latency = 1'b1;
        run_program("random_latency", 7);
        random_latency = 1'b0;
        check_stores("random_latency");
        compare_word("random_latency", "fetch count", 7, fetch_addr.size());
        for (int i = 0; i < fetch_addr.size(); i++) begin
            compare_word("random_latency", "fetch address", reset_pc + 4 * i, fetch_addr[i]);
        end
        finish_test("random_latency");
    endtask

    task automatic halt_test();
        prepare_test();
        prog.push_back(addi_inst(1, 0, 12'd1));
        prog.push_back(addi_inst(1, 1, 12'd1));
        prog.push_back(ebreak_inst);
        run_program("halt", 3);
        repeat (8) @(negedge clk);
        compare_word("halt", "halted", 1, halted);
        compare_word("halt", "retire count", 3, retire_count);
        compare_word("halt", "request count", 3, req_count); // three fetches, no data access.
        compare_word("halt", "fetch count", 3, fetch_addr.size());
        finish_test("halt");
    endtask

    initial begin : main
        int checker_fails;
        reset          = 1'b1;
        random_latency = 1'b0;
        errors         = 0;
        failed         = 0;
        tests_run      = 0;
        arith_test();
        constant_test();
        load_store_test();
        zero_reg_test();
        random_latency_test();
        halt_test();
        checker_fails = u_dut.u_checker.fails;
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, failed, errors, checker_fails);
        if (errors == 0 && checker_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sim/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker (
    input logic clk,
    input logic reset,
    input logic mem_req,
    input logic mem_done,
    input logic retire,
    input logic halted
);

    logic outstanding;
    int   fails = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (mem_req) begin
            outstanding <= 1'b1;
        end else if (mem_done) begin
            outstanding <= 1'b0;
        end
    end

    req_while_busy: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> !mem_req)
        else begin
            $error("mem_req raised while a request is still outstanding");
            fails++;
        end

    req_after_halt: assert property (@(posedge clk) disable iff (reset)
        halted |=> !mem_req && halted)
        else begin
            $error("mem_req issued or halted dropped after the core halted");
            fails++;
        end

    retire_pulse: assert property (@(posedge clk) disable iff (reset)
        retire |=> !retire)
        else begin
            $error("retire stayed high for more than one cycle");
            fails++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !mem_req && !retire && !halted)
        else begin
            $error("core outputs active right after reset");
            fails++;
        end

endmodule

bind cpu_top cpu_checker u_checker (
    .clk(clk), .reset(reset), .mem_req(mem_req), .mem_done(mem_done),
    .retire(retire), .halted(halted)
);

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter int              nregs    = 16,
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clk,
    input  logic            reset,
    output logic            mem_req,
    output logic            mem_we,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_wdata,
    input  logic [xlen-1:0] mem_rdata,
    input  logic            mem_done,
    output logic            retire,
    output logic            halted
);

    localparam int aw = $clog2(nregs);

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();

    logic [inst_width-1:0] inst;
    logic                  inst_valid;
    logic [aw-1:0]         raddr1;
    logic [aw-1:0]         raddr2;
    logic [aw-1:0]         des;
    logic [aw-1:0]         waddr;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [xlen-1:0]       src1;
    logic [xlen-1:0]       src2;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       wdata;
    logic [xlen-1:0]       load_data;
    cmd_t                  cmd;
    logic                  we;
    logic                  lsu_done;

    ifu #(.reset_pc(reset_pc)) u_ifu (
        .clk(clk), .reset(reset), .bus(fetch_bus), .retire(retire),
        .halt(halted), .inst(inst), .inst_valid(inst_valid)
    );

    idu #(.nregs(nregs)) u_idu (
        .inst(inst), .inst_valid(inst_valid), .raddr1(raddr1), .raddr2(raddr2),
        .rdata1(rdata1), .rdata2(rdata2), .src1(src1), .src2(src2),
        .des(des), .imm(imm), .cmd(cmd)
    );

    regfile #(.nregs(nregs)) u_regfile (
        .clk(clk), .reset(reset), .raddr1(raddr1), .raddr2(raddr2),
        .rdata1(rdata1), .rdata2(rdata2), .we(we), .waddr(waddr), .wdata(wdata)
    );

    exu #(.nregs(nregs)) u_exu (
        .clk(clk), .reset(reset), .inst_valid(inst_valid), .cmd(cmd),
        .src1(src1), .src2(src2), .imm(imm), .des(des), .load_data(load_data),
        .lsu_done(lsu_done), .we(we), .waddr(waddr), .wdata(wdata),
        .retire(retire), .halted(halted)
    );

    lsu u_lsu (
        .clk(clk), .reset(reset), .cmd(cmd), .src1(src1), .src2(src2), .imm(imm),
        .bus(data_bus), .load_data(load_data), .lsu_done(lsu_done)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .reset(reset), .fetch_bus(fetch_bus), .data_bus(data_bus),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_done(mem_done)
    );

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import cpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    mem_bus_if.slave        fetch_bus,
    mem_bus_if.slave        data_bus,
    output logic            mem_req,
    output logic            mem_we,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_wdata,
    input  logic [xlen-1:0] mem_rdata,
    input  logic            mem_done
);

    logic busy;
    logic owner_data;
    logic fetch_pend;
    logic data_pend;
    logic fetch_want;
    logic data_want;
    logic grant;
    logic sel_data;

    assign fetch_want = fetch_bus.req || fetch_pend;
    assign data_want  = data_bus.req || data_pend;
    assign grant      = !busy && (fetch_want || data_want);
    assign sel_data   = busy ? owner_data : data_want; // lsu wins a tie.

    assign mem_req   = grant;
    assign mem_we    = sel_data ? data_bus.we : fetch_bus.we;
    assign mem_addr  = sel_data ? data_bus.addr : fetch_bus.addr;
    assign mem_wdata = sel_data ? data_bus.wdata : fetch_bus.wdata;

    assign fetch_bus.rdata = mem_rdata;
    assign data_bus.rdata  = mem_rdata;
    assign fetch_bus.done  = busy && !owner_data && mem_done;
    assign data_bus.done   = busy && owner_data && mem_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            owner_data <= 1'b0;
            fetch_pend <= 1'b0;
            data_pend  <= 1'b0;
        end else begin
            if (grant) begin
                busy       <= 1'b1;
                owner_data <= data_want;
            end else if (busy && mem_done) begin
                busy <= 1'b0;
            end
            fetch_pend <= fetch_want && !(grant && !data_want); // wait for the bus.
            data_pend  <= data_want && !grant;
        end
    end

endmodule

/* rtl/lsu.sv */
`timescale 1ns/1ps

module lsu import cpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  cmd_t            cmd,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic [xlen-1:0] imm,
    mem_bus_if.master       bus,
    output logic [xlen-1:0] load_data,
    output logic            lsu_done
);

    logic            busy;
    logic            is_mem;
    logic [xlen-1:0] load_q;

    assign is_mem = (cmd == CMD_LOAD) || (cmd == CMD_STORE);

    // operands stay stable while the instruction is held, so the bus fields hold too
    assign bus.req   = is_mem && !busy;
    assign bus.we    = (cmd == CMD_STORE);
    assign bus.addr  = src1 + imm;
    assign bus.wdata = src2;

    assign lsu_done  = busy && bus.done;
    assign load_data = lsu_done ? bus.rdata : load_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (bus.req) begin
            busy <= 1'b1;
        end else if (lsu_done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lsu_done && !bus.we) begin
            load_q <= bus.rdata;
        end
    end

endmodule

/* rtl/exu.sv */
`timescale 1ns/1ps

module exu import cpu_pkg::*; #(
    parameter int nregs = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     inst_valid,
    input  cmd_t                     cmd,
    input  logic [xlen-1:0]          src1,
    input  logic [xlen-1:0]          src2,
    input  logic [xlen-1:0]          imm,
    input  logic [$clog2(nregs)-1:0] des,
    input  logic [xlen-1:0]          load_data,
    input  logic                     lsu_done,
    output logic                     we,
    output logic [$clog2(nregs)-1:0] waddr,
    output logic [xlen-1:0]          wdata,
    output logic                     retire,
    output logic                     halted
);

    logic            is_mem;
    logic            halt_now;
    logic            halted_q;
    logic [xlen-1:0] sum;

    assign is_mem   = (cmd == CMD_LOAD) || (cmd == CMD_STORE);
    assign retire   = inst_valid && (is_mem ? lsu_done : 1'b1);
    assign sum      = src1 + (src2 | imm); // decoder zeroes the unused operand.
    assign we       = retire && (cmd == CMD_ADD || cmd == CMD_LOAD);
    assign waddr    = des;
    assign wdata    = (cmd == CMD_LOAD) ? load_data : sum;
    assign halt_now = retire && (cmd == CMD_HALT);
    assign halted   = halted_q || halt_now; // seen by ifu in the ebreak retire cycle.

    always_ff @(posedge clk) begin
        if (reset) begin
            halted_q <= 1'b0;
        end else if (halt_now) begin
            halted_q <= 1'b1;
        end
    end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ps

module regfile import cpu_pkg::*; #(
    parameter int nregs = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [$clog2(nregs)-1:0] raddr1,
    input  logic [$clog2(nregs)-1:0] raddr2,
    output logic [xlen-1:0]          rdata1,
    output logic [xlen-1:0]          rdata2,
    input  logic                     we,
    input  logic [$clog2(nregs)-1:0] waddr,
    input  logic [xlen-1:0]          wdata
);

    logic [xlen-1:0] regs [nregs];

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata; // x0 stays zero.
        end
    end

endmodule

/* rtl/idu.sv */
`timescale 1ns/1ps

module idu import cpu_pkg::*; #(
    parameter int nregs = 16
) (
    input  logic [inst_width-1:0]    inst,
    input  logic                     inst_valid,
    output logic [$clog2(nregs)-1:0] raddr1,
    output logic [$clog2(nregs)-1:0] raddr2,
    input  logic [xlen-1:0]          rdata1,
    input  logic [xlen-1:0]          rdata2,
    output logic [xlen-1:0]          src1,
    output logic [xlen-1:0]          src2,
    output logic [$clog2(nregs)-1:0] des,
    output logic [xlen-1:0]          imm,
    output cmd_t                     cmd
);

    localparam int aw = $clog2(nregs);

    typedef enum logic [1:0] {IMM_N, IMM_I, IMM_S, IMM_U} imm_t;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_t       imm_type;
    logic       src1_en;
    logic       src2_en;
    logic       write_en;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign raddr1 = src1_en ? inst[15 +: aw] : '0;
    assign src1   = src1_en ? rdata1 : '0;
    assign raddr2 = src2_en ? inst[20 +: aw] : '0;
    assign src2   = src2_en ? rdata2 : '0;
    assign des    = write_en ? inst[7 +: aw] : '0;

    always_comb begin
        case (imm_type)
            IMM_I:   imm = {{20{inst[31]}}, inst[31:20]};
            IMM_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            IMM_U:   imm = {inst[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        imm_type = IMM_N;
        cmd      = CMD_NOP;
        src1_en  = 1'b0;
        src2_en  = 1'b0;
        write_en = 1'b0;
        if (inst_valid) begin
            case (opcode)
                op_imm: begin
                    if (funct3 == 3'b000) begin // addi.
                        imm_type = IMM_I;
                        cmd      = CMD_ADD;
                        src1_en  = 1'b1;
                        write_en = 1'b1;
                    end
                end
                op_reg: begin
                    if (funct3 == 3'b000 && funct7 == 7'b0) begin // add.
                        cmd      = CMD_ADD;
                        src1_en  = 1'b1;
                        src2_en  = 1'b1;
                        write_en = 1'b1;
                    end
                end
                op_lui: begin // rs1 reads as zero, so the add passes imm.
                    imm_type = IMM_U;
                    cmd      = CMD_ADD;
                    write_en = 1'b1;
                end
                op_load: begin
                    if (funct3 == 3'b010) begin // lw.
                        imm_type = IMM_I;
                        cmd      = CMD_LOAD;
                        src1_en  = 1'b1;
                        write_en = 1'b1;
                    end
                end
                op_store: begin
                    if (funct3 == 3'b010) begin // sw.
                        imm_type = IMM_S;
                        cmd      = CMD_STORE;
                        src1_en  = 1'b1;
                        src2_en  = 1'b1;
                    end
                end
                op_system: begin
                    if (inst[31:7] == 25'h0002000) begin // ebreak.
                        cmd = CMD_HALT;
                    end
                end
                default: cmd = CMD_NOP;
            endcase
        end
    end

endmodule

/* rtl/ifu.sv */
`timescale 1ns/1ps

module ifu import cpu_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    mem_bus_if.master             bus,
    input  logic                  retire,
    input  logic                  halt,
    output logic [inst_width-1:0] inst,
    output logic                  inst_valid
);

    typedef enum logic {S_FETCH, S_HOLD} state_t;

    state_t                state;
    logic                  boot;
    logic                  req_q;
    logic [xlen-1:0]       pc;
    logic [inst_width-1:0] inst_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
            boot  <= 1'b1;
            req_q <= 1'b0;
            pc    <= reset_pc;
        end else begin
            boot  <= 1'b0;
            req_q <= boot; // first fetch right after reset.
            case (state)
                S_FETCH: begin
                    if (bus.done) begin
                        state <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    if (retire) begin
                        state <= S_FETCH;
                        pc    <= pc + xlen'(4);
                        req_q <= ~halt; // no fetch after ebreak.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && bus.done) begin
            inst_q <= bus.rdata;
        end
    end

    assign bus.req    = req_q;
    assign bus.we     = 1'b0;
    assign bus.addr   = pc;
    assign bus.wdata  = '0;
    assign inst       = inst_q;
    assign inst_valid = (state == S_HOLD);

endmodule

/* rtl/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if import cpu_pkg::*; ();

    logic            req;
    logic            we;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] rdata;
    logic            done;

    modport master (output req, we, addr, wdata, input rdata, done);
    modport slave  (input req, we, addr, wdata, output rdata, done);

endinterface

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int inst_width = 32;

    typedef enum logic [2:0] {
        CMD_NOP,
        CMD_ADD,
        CMD_LOAD,
        CMD_STORE,
        CMD_HALT
    } cmd_t;

    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

endpackage
